// File: hw/renamePkg.sv
package renamePkg;

    // Register file sizes
    localparam int numArchRegs = 32;
    localparam int numPhysRegs = 64;

    // Architectural register number, x0 is hardwired to zero
    typedef logic [4:0] ArchReg;

    // Physical register tag
    typedef logic [5:0] PhysTag;

    // Sequence number that wraps around
    // Ordering between two of them uses the signed difference
    typedef logic [6:0] SeqNum;

    // Load queue or store queue index
    typedef logic [4:0] LsIndex;

    // Functional unit a micro-op is sent to
    typedef enum logic [2:0] {
        fuInt    = 3'd0,
        fuMul    = 3'd1,
        fuDiv    = 3'd2,
        fuLoad   = 3'd3,
        fuStore  = 3'd4,
        fuAtomic = 3'd5,
        fuBranch = 3'd6
    } FuType;

endpackage

// File: hw/renameTable.sv
module renameTable #(
    parameter int issueWidth  = 2,
    parameter int commitWidth = 2,
    parameter int wbWidth     = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               branchTaken,

    input  renamePkg::ArchReg  lookupRegs     [2*issueWidth],
    output renamePkg::PhysTag  lookupTags     [2*issueWidth],
    output logic               lookupReady    [2*issueWidth],

    input  logic               issueValid     [issueWidth],
    input  renamePkg::ArchReg  issueRegs      [issueWidth],
    input  renamePkg::PhysTag  issueTags      [issueWidth],

    input  logic               commitValid    [commitWidth],
    input  renamePkg::ArchReg  commitRegs     [commitWidth],
    input  renamePkg::PhysTag  commitTags     [commitWidth],
    output renamePkg::PhysTag  commitPrevTags [commitWidth],

    input  logic               wbValid        [wbWidth],
    input  renamePkg::PhysTag  wbTags         [wbWidth]
);

    renamePkg::PhysTag specMap [renamePkg::numArchRegs];
    renamePkg::PhysTag comMap  [renamePkg::numArchRegs];
    renamePkg::PhysTag comNext [renamePkg::numArchRegs];
    logic [renamePkg::numPhysRegs-1:0] readyVec;

    // Source lookup with bypass from older lanes of the same group
    always_comb begin
        for (int i = 0; i < issueWidth; i++) begin
            for (int s = 0; s < 2; s++) begin
                lookupTags[2*i+s] = specMap[lookupRegs[2*i+s]];
                lookupReady[2*i+s] = readyVec[specMap[lookupRegs[2*i+s]]];
                // The youngest older writer wins
                for (int j = 0; j < i; j++) begin
                    if (issueValid[j] && issueRegs[j] != '0 &&
                            issueRegs[j] == lookupRegs[2*i+s]) begin
                        lookupTags[2*i+s] = issueTags[j];
                        lookupReady[2*i+s] = 1'b0;
                    end
                end
            end
        end
    end

    // Committed map with this cycle's commits applied in lane order.
    // A second commit to the same register sees the first one's tag as previous
    always_comb begin
        comNext = comMap;
        for (int i = 0; i < commitWidth; i++) begin
            commitPrevTags[i] = comNext[commitRegs[i]];
            if (commitValid[i] && commitRegs[i] != '0) begin
                comNext[commitRegs[i]] = commitTags[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < renamePkg::numArchRegs; r++) begin
                specMap[r] <= renamePkg::PhysTag'(r);
                comMap[r] <= renamePkg::PhysTag'(r);
            end
            readyVec <= '1;
        end else begin
            comMap <= comNext;
            if (branchTaken) begin
                // Squash everything speculative
                specMap <= comNext;
                readyVec <= '1;
            end else begin
                for (int i = 0; i < issueWidth; i++) begin
                    if (issueValid[i]) begin
                        if (issueRegs[i] != '0) begin
                            specMap[issueRegs[i]] <= issueTags[i];
                        end
                        readyVec[issueTags[i]] <= 1'b0;
                    end
                end
                for (int i = 0; i < wbWidth; i++) begin
                    if (wbValid[i]) begin
                        readyVec[wbTags[i]] <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: hw/freeTagFifo.sv
module freeTagFifo #(
    parameter int issueWidth  = 2,
    parameter int commitWidth = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               branchTaken,

    input  logic               allocValid  [issueWidth],
    output renamePkg::PhysTag  allocTags   [issueWidth],

    input  logic               commitValid [commitWidth],
    input  logic               freeValid   [commitWidth],
    input  renamePkg::PhysTag  freeTags    [commitWidth],

    output logic [6:0]         freeCount
);

    localparam int depth   = renamePkg::numPhysRegs - renamePkg::numArchRegs;
    localparam int idxBits = $clog2(depth);

    // Pointers carry one wrap bit above the index
    logic [idxBits:0]   specRdPtr;
    logic [idxBits:0]   comRdPtr;
    logic [idxBits:0]   wrPtr;
    logic [idxBits:0]   specRdNext;
    logic [idxBits:0]   comRdNext;
    logic [idxBits:0]   wrNext;
    logic [idxBits-1:0] rdIdx;
    logic [idxBits-1:0] wrIdx [commitWidth];

    renamePkg::PhysTag mem [depth];

    assign freeCount = {1'b0, wrPtr - specRdPtr};

    // Each allocating lane takes the entry after the previous allocating lane
    always_comb begin
        specRdNext = specRdPtr;
        rdIdx = '0;
        for (int i = 0; i < issueWidth; i++) begin
            rdIdx = specRdNext[idxBits-1:0];
            allocTags[i] = mem[rdIdx];
            if (allocValid[i]) begin
                specRdNext = specRdNext + 1'b1;
            end
        end
        comRdNext = comRdPtr;
        for (int i = 0; i < commitWidth; i++) begin
            if (commitValid[i]) begin
                comRdNext = comRdNext + 1'b1;
            end
        end
    end

    // Frees are packed in lane order from the write pointer
    always_comb begin
        wrNext = wrPtr;
        for (int i = 0; i < commitWidth; i++) begin
            wrIdx[i] = wrNext[idxBits-1:0];
            if (freeValid[i]) begin
                wrNext = wrNext + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < depth; k++) begin
                mem[k] <= renamePkg::PhysTag'(renamePkg::numArchRegs + k);
            end
            specRdPtr <= '0;
            comRdPtr <= '0;
            wrPtr <= (idxBits+1)'(depth);
        end else begin
            // Squashed tags come back by rewinding to the committed pointer
            specRdPtr <= branchTaken ? comRdNext : specRdNext;
            comRdPtr <= comRdNext;
            wrPtr <= wrNext;
            for (int i = 0; i < commitWidth; i++) begin
                if (freeValid[i]) begin
                    mem[wrIdx[i]] <= freeTags[i];
                end
            end
        end
    end

endmodule

// File: hw/renameStage.sv
module renameStage #(
    parameter int issueWidth  = 2,
    parameter int commitWidth = 2,
    parameter int wbWidth     = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               en,

    input  logic               uopValid      [issueWidth],
    input  renamePkg::FuType   uopFu         [issueWidth],
    input  renamePkg::ArchReg  uopRs0        [issueWidth],
    input  renamePkg::ArchReg  uopRs1        [issueWidth],
    input  renamePkg::ArchReg  uopRd         [issueWidth],

    input  logic               commitValid   [commitWidth],
    input  renamePkg::ArchReg  commitRd      [commitWidth],
    input  renamePkg::PhysTag  commitTag     [commitWidth],

    input  logic               wbValid       [wbWidth],
    input  renamePkg::PhysTag  wbTag         [wbWidth],

    input  logic               branchTaken,
    input  renamePkg::SeqNum   branchSqN,
    input  renamePkg::LsIndex  branchLoadSqN,
    input  renamePkg::LsIndex  branchStoreSqN,

    output logic               stall,
    output logic               outValid      [issueWidth],
    output renamePkg::FuType   outFu         [issueWidth],
    output renamePkg::ArchReg  outRd         [issueWidth],
    output renamePkg::SeqNum   outSqN        [issueWidth],
    output renamePkg::LsIndex  outLoadSqN    [issueWidth],
    output renamePkg::LsIndex  outStoreSqN   [issueWidth],
    output renamePkg::PhysTag  outTagA       [issueWidth],
    output renamePkg::PhysTag  outTagB       [issueWidth],
    output renamePkg::PhysTag  outTagDst     [issueWidth],
    output logic               outAvailA     [issueWidth],
    output logic               outAvailB     [issueWidth],
    output renamePkg::SeqNum   nextSqN,
    output renamePkg::LsIndex  nextLoadSqN,
    output renamePkg::LsIndex  nextStoreSqN
);

    logic              needTag     [issueWidth];
    logic              allocValid  [issueWidth];
    renamePkg::PhysTag allocTags   [issueWidth];
    renamePkg::ArchReg lookupRegs  [2*issueWidth];
    renamePkg::PhysTag lookupTags  [2*issueWidth];
    logic              lookupReady [2*issueWidth];

    renamePkg::PhysTag commitPrevTags [commitWidth];
    logic              comAdvance     [commitWidth];
    logic              freeValid      [commitWidth];
    renamePkg::PhysTag freeTags       [commitWidth];

    logic [6:0] freeCount;
    logic [6:0] needCount;
    logic       accept;

    renamePkg::SeqNum  sqCnt;
    renamePkg::LsIndex loadCnt;
    renamePkg::LsIndex storeCnt;
    renamePkg::SeqNum  sqRun;
    renamePkg::LsIndex loadRun;
    renamePkg::LsIndex storeRun;
    renamePkg::SeqNum  laneSqN    [issueWidth];
    renamePkg::LsIndex laneLoad   [issueWidth];
    renamePkg::LsIndex laneStore  [issueWidth];

    function automatic logic wbHit(renamePkg::PhysTag tag);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < wbWidth; k++) begin
            if (wbValid[k] && wbTag[k] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Atomics always get a tag for their intermediate result, even with rd x0
    always_comb begin
        needCount = '0;
        for (int i = 0; i < issueWidth; i++) begin
            needTag[i] = uopValid[i] &&
                (uopRd[i] != '0 || uopFu[i] == renamePkg::fuAtomic);
            needCount = needCount + 7'(needTag[i]);
        end
    end

    assign stall  = en && (needCount > freeCount);
    assign accept = en && !stall && !branchTaken;

    // Sequence, load and store numbering in lane order
    always_comb begin
        sqRun = sqCnt;
        loadRun = loadCnt;
        storeRun = storeCnt;
        for (int i = 0; i < issueWidth; i++) begin
            allocValid[i] = accept && needTag[i];
            lookupRegs[2*i] = uopRs0[i];
            lookupRegs[2*i+1] = uopRs1[i];
            laneSqN[i] = sqRun;
            laneLoad[i] = loadRun;
            if (uopValid[i]) begin
                sqRun = sqRun + 1'b1;
                if (uopFu[i] == renamePkg::fuLoad || uopFu[i] == renamePkg::fuAtomic) begin
                    loadRun = loadRun + 1'b1;
                end
                if (uopFu[i] == renamePkg::fuStore || uopFu[i] == renamePkg::fuAtomic) begin
                    storeRun = storeRun + 1'b1;
                end
            end
            laneStore[i] = storeRun;
        end
    end

    // A commit with rd x0 but a real tag is an atomic whose result is dropped,
    // so its own tag goes straight back to the list
    always_comb begin
        for (int i = 0; i < commitWidth; i++) begin
            comAdvance[i] = commitValid[i] && commitTag[i] != '0;
            freeValid[i] = comAdvance[i];
            freeTags[i] = (commitRd[i] != '0) ? commitPrevTags[i] : commitTag[i];
        end
    end

    assign nextSqN      = sqCnt;
    assign nextLoadSqN  = loadCnt;
    assign nextStoreSqN = storeCnt + 1'b1;

    renameTable #(
        .issueWidth (issueWidth),
        .commitWidth(commitWidth),
        .wbWidth    (wbWidth)
    ) i_renameTable (
        .clk           (clk),
        .rst           (rst),
        .branchTaken   (branchTaken),
        .lookupRegs    (lookupRegs),
        .lookupTags    (lookupTags),
        .lookupReady   (lookupReady),
        .issueValid    (allocValid),
        .issueRegs     (uopRd),
        .issueTags     (allocTags),
        .commitValid   (commitValid),
        .commitRegs    (commitRd),
        .commitTags    (commitTag),
        .commitPrevTags(commitPrevTags),
        .wbValid       (wbValid),
        .wbTags        (wbTag)
    );

    freeTagFifo #(
        .issueWidth (issueWidth),
        .commitWidth(commitWidth)
    ) i_freeTagFifo (
        .clk        (clk),
        .rst        (rst),
        .branchTaken(branchTaken),
        .allocValid (allocValid),
        .allocTags  (allocTags),
        .commitValid(comAdvance),
        .freeValid  (freeValid),
        .freeTags   (freeTags),
        .freeCount  (freeCount)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            sqCnt <= '0;
            loadCnt <= '0;
            storeCnt <= '1;
            for (int i = 0; i < issueWidth; i++) begin
                outValid[i] <= 1'b0;
            end
        end else if (branchTaken) begin
            sqCnt <= branchSqN + 1'b1;
            loadCnt <= branchLoadSqN;
            storeCnt <= branchStoreSqN;
            for (int i = 0; i < issueWidth; i++) begin
                outValid[i] <= 1'b0;
            end
        end else if (!en) begin
            for (int i = 0; i < issueWidth; i++) begin
                outValid[i] <= 1'b0;
            end
        end else if (!stall) begin
            sqCnt <= sqRun;
            loadCnt <= loadRun;
            storeCnt <= storeRun;
            for (int i = 0; i < issueWidth; i++) begin
                outValid[i] <= uopValid[i];
                outFu[i] <= uopFu[i];
                outRd[i] <= uopRd[i];
                outSqN[i] <= laneSqN[i];
                outLoadSqN[i] <= laneLoad[i];
                outStoreSqN[i] <= laneStore[i];
                outTagA[i] <= lookupTags[2*i];
                outTagB[i] <= lookupTags[2*i+1];
                outTagDst[i] <= needTag[i] ? allocTags[i] : '0;
                // Catch a writeback landing on the same edge as the lookup
                outAvailA[i] <= lookupReady[2*i] || wbHit(lookupTags[2*i]);
                outAvailB[i] <= lookupReady[2*i+1] || wbHit(lookupTags[2*i+1]);
            end
        end else begin
            // Held group keeps tracking writebacks
            for (int i = 0; i < issueWidth; i++) begin
                if (wbHit(outTagA[i])) begin
                    outAvailA[i] <= 1'b1;
                end
                if (wbHit(outTagB[i])) begin
                    outAvailB[i] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: tb/renameStageTb.sv
module renameStageTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int width = 2;

    logic              clk = 1'b0;
    logic              rst;
    logic              en;
    logic              uopValid    [width];
    renamePkg::FuType  uopFu       [width];
    renamePkg::ArchReg uopRs0      [width];
    renamePkg::ArchReg uopRs1      [width];
    renamePkg::ArchReg uopRd       [width];
    logic              commitValid [width];
    renamePkg::ArchReg commitRd    [width];
    renamePkg::PhysTag commitTag   [width];
    logic              wbValid     [width];
    renamePkg::PhysTag wbTag       [width];
    logic              branchTaken;
    renamePkg::SeqNum  branchSqN;
    renamePkg::LsIndex branchLoadSqN;
    renamePkg::LsIndex branchStoreSqN;
    logic              stall;
    logic              outValid    [width];
    renamePkg::FuType  outFu       [width];
    renamePkg::ArchReg outRd       [width];
    renamePkg::SeqNum  outSqN      [width];
    renamePkg::LsIndex outLoadSqN  [width];
    renamePkg::LsIndex outStoreSqN [width];
    renamePkg::PhysTag outTagA     [width];
    renamePkg::PhysTag outTagB     [width];
    renamePkg::PhysTag outTagDst   [width];
    logic              outAvailA   [width];
    logic              outAvailB   [width];
    renamePkg::SeqNum  nextSqN;
    renamePkg::LsIndex nextLoadSqN;
    renamePkg::LsIndex nextStoreSqN;

    // Reference model of the maps, ready bits, free list and counters
    renamePkg::PhysTag refSpec [renamePkg::numArchRegs];
    renamePkg::PhysTag refCom  [renamePkg::numArchRegs];
    logic [renamePkg::numPhysRegs-1:0] refReady;
    renamePkg::PhysTag freeQ [$];
    int                specOff;
    renamePkg::ArchReg allocRd [$];
    renamePkg::PhysTag allocTag [$];
    renamePkg::SeqNum  refSq;
    renamePkg::LsIndex refLoad;
    renamePkg::LsIndex refStore;

    renameStage #(
        .issueWidth (width),
        .commitWidth(width),
        .wbWidth    (width)
    ) i_renameStage (.*);

    always #4 clk = ~clk;

    task automatic reportFailure(string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic checkVal(string name, int got, int expected);
        assert (got == expected) else begin
            reportFailure($sformatf("mismatch %s: got 0x%0h, expected 0x%0h",
                name, got, expected));
        end
    endtask

    function automatic int randReg();
        return $urandom % 32;
    endfunction

    function automatic int randDest();
        return 1 + $urandom % 31;
    endfunction

    task automatic stepCycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic clearInputs();
        for (int i = 0; i < width; i++) begin
            uopValid[i] = 1'b0;
            uopFu[i] = renamePkg::fuInt;
            uopRs0[i] = '0;
            uopRs1[i] = '0;
            uopRd[i] = '0;
            commitValid[i] = 1'b0;
            commitRd[i] = '0;
            commitTag[i] = '0;
            wbValid[i] = 1'b0;
            wbTag[i] = '0;
        end
        branchTaken = 1'b0;
        branchSqN = '0;
        branchLoadSqN = '0;
        branchStoreSqN = '0;
    endtask

    task automatic driveUop(int lane, renamePkg::FuType fu, int rs0, int rs1, int rd);
        uopValid[lane] = 1'b1;
        uopFu[lane] = fu;
        uopRs0[lane] = renamePkg::ArchReg'(rs0);
        uopRs1[lane] = renamePkg::ArchReg'(rs1);
        uopRd[lane] = renamePkg::ArchReg'(rd);
    endtask

    task automatic resetDut();
        rst = 1'b1;
        en = 1'b1;
        clearInputs();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < renamePkg::numArchRegs; r++) begin
            refSpec[r] = renamePkg::PhysTag'(r);
            refCom[r] = renamePkg::PhysTag'(r);
        end
        refReady = '1;
        freeQ.delete();
        for (int k = renamePkg::numArchRegs; k < renamePkg::numPhysRegs; k++) begin
            freeQ.push_back(renamePkg::PhysTag'(k));
        end
        specOff = 0;
        refSq = '0;
        refLoad = '0;
        refStore = '1;
    endtask

    task automatic checkNext();
        checkVal("nextSqN", nextSqN, refSq);
        checkVal("nextLoadSqN", nextLoadSqN, refLoad);
        checkVal("nextStoreSqN", nextStoreSqN, renamePkg::LsIndex'(refStore + 1'b1));
    endtask

    // Predict the renamed group, clock it in and compare every lane
    task automatic issueGroup();
        renamePkg::PhysTag expA   [width];
        renamePkg::PhysTag expB   [width];
        renamePkg::PhysTag expDst [width];
        logic              expAvA [width];
        logic              expAvB [width];
        renamePkg::SeqNum  expSq  [width];
        renamePkg::LsIndex expLd  [width];
        renamePkg::LsIndex expSt  [width];
        #1;
        checkVal("stall", stall, 0);
        for (int i = 0; i < width; i++) begin
            expA[i] = refSpec[uopRs0[i]];
            expB[i] = refSpec[uopRs1[i]];
            expAvA[i] = refReady[expA[i]];
            expAvB[i] = refReady[expB[i]];
            // Older lane writing the source register
            for (int j = 0; j < i; j++) begin
                if (uopValid[j] && uopRd[j] != '0 && uopRd[j] == uopRs0[i]) begin
                    expA[i] = expDst[j];
                    expAvA[i] = 1'b0;
                end
                if (uopValid[j] && uopRd[j] != '0 && uopRd[j] == uopRs1[i]) begin
                    expB[i] = expDst[j];
                    expAvB[i] = 1'b0;
                end
            end
            expDst[i] = '0;
            expSq[i] = refSq;
            expLd[i] = refLoad;
            if (uopValid[i]) begin
                refSq++;
                if (uopFu[i] == renamePkg::fuLoad || uopFu[i] == renamePkg::fuAtomic) begin
                    refLoad++;
                end
                if (uopFu[i] == renamePkg::fuStore || uopFu[i] == renamePkg::fuAtomic) begin
                    refStore++;
                end
                if (uopRd[i] != '0 || uopFu[i] == renamePkg::fuAtomic) begin
                    expDst[i] = freeQ[specOff];
                    specOff++;
                    allocRd.push_back(uopRd[i]);
                    allocTag.push_back(expDst[i]);
                end
            end
            expSt[i] = refStore;
        end
        for (int i = 0; i < width; i++) begin
            if (expDst[i] != '0) begin
                refReady[expDst[i]] = 1'b0;
                if (uopRd[i] != '0) begin
                    refSpec[uopRd[i]] = expDst[i];
                end
            end
        end
        stepCycle();
        for (int i = 0; i < width; i++) begin
            checkVal($sformatf("outValid[%0d]", i), outValid[i], uopValid[i]);
            if (uopValid[i]) begin
                checkVal($sformatf("outFu[%0d]", i), outFu[i], uopFu[i]);
                checkVal($sformatf("outRd[%0d]", i), outRd[i], uopRd[i]);
                checkVal($sformatf("outSqN[%0d]", i), outSqN[i], expSq[i]);
                checkVal($sformatf("outLoadSqN[%0d]", i), outLoadSqN[i], expLd[i]);
                checkVal($sformatf("outStoreSqN[%0d]", i), outStoreSqN[i], expSt[i]);
                checkVal($sformatf("outTagA[%0d]", i), outTagA[i], expA[i]);
                checkVal($sformatf("outTagB[%0d]", i), outTagB[i], expB[i]);
                checkVal($sformatf("outTagDst[%0d]", i), outTagDst[i], expDst[i]);
                checkVal($sformatf("outAvailA[%0d]", i), outAvailA[i], expAvA[i]);
                checkVal($sformatf("outAvailB[%0d]", i), outAvailB[i], expAvB[i]);
            end
        end
        checkNext();
    endtask

    // Commit the n oldest allocations, in order, from lane 0 upward
    task automatic commitOldest(int n);
        renamePkg::PhysTag freed;
        for (int i = 0; i < n; i++) begin
            commitValid[i] = 1'b1;
            commitRd[i] = allocRd.pop_front();
            commitTag[i] = allocTag.pop_front();
            freed = (commitRd[i] != '0) ? refCom[commitRd[i]] : commitTag[i];
            if (commitRd[i] != '0) begin
                refCom[commitRd[i]] = commitTag[i];
            end
            void'(freeQ.pop_front());
            specOff--;
            freeQ.push_back(freed);
        end
    endtask

    task automatic waitStallLow(int maxCycles);
        int n;
        n = 0;
        #1;
        while (stall) begin
            if (n >= maxCycles) begin
                reportFailure("timeout: stall did not drop after tags were freed");
            end else begin
                n++;
                stepCycle();
                #1;
            end
        end
    endtask

    task automatic testResetLookup();
        int r [4];
        for (int k = 0; k < 4; k++) begin
            r[k] = randReg();
        end
        checkVal("outValid[0]", outValid[0], 0);
        checkVal("outValid[1]", outValid[1], 0);
        checkNext();
        driveUop(0, renamePkg::fuInt, r[0], r[1], 0);
        driveUop(1, renamePkg::fuInt, r[2], r[3], 0);
        issueGroup();
        checkVal("outTagA[0]", outTagA[0], r[0]);
        checkVal("outTagB[1]", outTagB[1], r[3]);
        checkVal("nextSqN", nextSqN, 2);
        clearInputs();
    endtask

    task automatic testInGroupBypass();
        int r;
        int s;
        r = randDest();
        s = randReg();
        driveUop(0, renamePkg::fuInt, s, s, r);
        driveUop(1, renamePkg::fuInt, r, 0, (r % 31) + 1);
        issueGroup();
        checkVal("outTagDst[0]", outTagDst[0], 32);
        checkVal("outTagDst[1]", outTagDst[1], 33);
        checkVal("outTagA[1]", outTagA[1], 32);
        checkVal("outAvailA[1]", outAvailA[1], 0);
        clearInputs();
        wbValid[0] = 1'b1;
        wbTag[0] = 6'd32;
        refReady[32] = 1'b1;
        stepCycle();
        clearInputs();
        driveUop(0, renamePkg::fuInt, r, 0, 0);
        issueGroup();
        checkVal("outAvailA[0]", outAvailA[0], 1);
        clearInputs();
    endtask

    task automatic testLsIndices();
        renamePkg::FuType fu;
        for (int g = 0; g < 6; g++) begin
            for (int i = 0; i < width; i++) begin
                // Load, store or atomic
                fu = renamePkg::FuType'(3 + $urandom % 3);
                driveUop(i, fu, randReg(), randReg(),
                    (fu == renamePkg::fuAtomic) ? randReg() : 0);
            end
            if (g == 5) begin
                uopValid[0] = 1'b0;
            end
            issueGroup();
            clearInputs();
        end
    endtask

    task automatic testFreeListStall();
        logic              heldValid [width];
        renamePkg::SeqNum  heldSq    [width];
        renamePkg::PhysTag heldB     [width];
        renamePkg::PhysTag heldDst   [width];
        int                d;
        // Lane 1 reads lane 0's result so its first source is still pending
        while (freeQ.size() - specOff > 0) begin
            d = randDest();
            driveUop(0, renamePkg::fuInt, randReg(), randReg(), d);
            driveUop(1, renamePkg::fuInt, d, randReg(),
                (freeQ.size() - specOff >= 2) ? randDest() : 0);
            issueGroup();
            clearInputs();
        end
        for (int i = 0; i < width; i++) begin
            heldValid[i] = outValid[i];
            heldSq[i] = outSqN[i];
            heldB[i] = outTagB[i];
            heldDst[i] = outTagDst[i];
        end
        checkVal("outAvailA[1]", outAvailA[1], 0);
        driveUop(0, renamePkg::fuInt, randReg(), randReg(), randDest());
        driveUop(1, renamePkg::fuInt, randReg(), randReg(), 0);
        // Writeback to a held source and two commits while stalled
        wbValid[0] = 1'b1;
        wbTag[0] = outTagA[1];
        refReady[outTagA[1]] = 1'b1;
        commitOldest(2);
        #1;
        checkVal("stall", stall, 1);
        stepCycle();
        for (int i = 0; i < width; i++) begin
            checkVal($sformatf("outValid[%0d]", i), outValid[i], heldValid[i]);
            checkVal($sformatf("outSqN[%0d]", i), outSqN[i], heldSq[i]);
            checkVal($sformatf("outTagB[%0d]", i), outTagB[i], heldB[i]);
            checkVal($sformatf("outTagDst[%0d]", i), outTagDst[i], heldDst[i]);
            wbValid[i] = 1'b0;
            commitValid[i] = 1'b0;
        end
        checkVal("outAvailA[1]", outAvailA[1], 1);
        checkNext();
        waitStallLow(4);
        issueGroup();
        clearInputs();
    endtask

    task automatic testBranchRecovery();
        renamePkg::PhysTag squashed [$];
        renamePkg::ArchReg comReg;
        renamePkg::SeqNum  brSq;
        commitOldest(2);
        comReg = (commitRd[0] != '0) ? commitRd[0] : commitRd[1];
        stepCycle();
        clearInputs();
        brSq = renamePkg::SeqNum'($urandom);
        branchTaken = 1'b1;
        branchSqN = brSq;
        branchLoadSqN = renamePkg::LsIndex'($urandom);
        branchStoreSqN = renamePkg::LsIndex'($urandom);
        // Everything not committed is squashed
        squashed = allocTag;
        allocTag.delete();
        allocRd.delete();
        specOff = 0;
        refSpec = refCom;
        refReady = '1;
        refSq = brSq + 1'b1;
        refLoad = branchLoadSqN;
        refStore = branchStoreSqN;
        stepCycle();
        checkVal("outValid[0]", outValid[0], 0);
        checkVal("outValid[1]", outValid[1], 0);
        checkVal("nextSqN", nextSqN, renamePkg::SeqNum'(brSq + 1'b1));
        checkNext();
        clearInputs();
        driveUop(0, renamePkg::fuInt, comReg, randReg(), randDest());
        driveUop(1, renamePkg::fuLoad, randReg(), randReg(), randDest());
        issueGroup();
        checkVal("outTagA[0]", outTagA[0], refCom[comReg]);
        checkVal("outTagDst[0]", outTagDst[0], squashed[0]);
        checkVal("outTagDst[1]", outTagDst[1], squashed[1]);
        clearInputs();
    endtask

    initial begin
        void'($urandom(23039));
        resetDut();
        testResetLookup();
        testInGroupBypass();
        testLsIndices();
        testFreeListStall();
        testBranchRecovery();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: renameCore.f
hw/renamePkg.sv
hw/renameTable.sv
hw/freeTagFifo.sv
hw/renameStage.sv
tb/renameStageTb.sv

// File: Bender.yml
package:
  name: renameCore

sources:
  - hw/renamePkg.sv
  - hw/renameTable.sv
  - hw/freeTagFifo.sv
  - hw/renameStage.sv
  - target: simulation
    files:
      - tb/renameStageTb.sv
